// File: host_pkg.sv
`default_nettype none

package host_pkg;

  // Sizing
  localparam int NUM_HARTS = 4;
  localparam int ADDR_W    = 20;
  localparam int DATA_W    = 64;
  localparam int HART_W    = 2;
  localparam int TRACE_W   = 11;
  localparam int EXIT_W    = 8;
  localparam int TAG_W     = 4;

  // Address map fields
  localparam int HART_LSB = 12;
  localparam int REG_W    = 4;

  typedef logic [HART_W-1:0]  hart_id_t;
  typedef logic [ADDR_W-1:0]  io_addr_t;
  typedef logic [DATA_W-1:0]  io_data_t;
  typedef logic [TRACE_W-1:0] trace_en_t;
  typedef logic [EXIT_W-1:0]  exit_code_t;
  typedef logic [TAG_W-1:0]   tag_t;

  // Everything outside hart bits 13:12 and register bits 3:0
  localparam io_addr_t ADDR_RSVD_MASK = io_addr_t'(20'hfcff0);

  typedef enum logic [0:0] {
    IO_READ  = 1'b0,
    IO_WRITE = 1'b1
  } io_op_e;

  typedef enum logic [REG_W-1:0] {
    REG_TRACE_EN = 4'd0,
    REG_FINISH   = 4'd1
  } host_reg_e;

  typedef struct packed {
    io_op_e   op;
    io_addr_t addr;
    tag_t     tag;
    io_data_t data;
  } io_cmd_t;

  typedef struct packed {
    io_op_e   op;
    tag_t     tag;
    logic     err;
    io_data_t data;
  } io_resp_t;

  // Decoded stage 1 request shared by all hart units
  typedef struct packed {
    logic      valid;
    io_op_e    op;
    host_reg_e reg_sel;
    hart_id_t  hart;
    tag_t      tag;
    logic      err;
    io_data_t  data;
  } hart_req_t;

  // Stage 2 result from one hart unit
  typedef struct packed {
    logic     valid;
    io_op_e   op;
    tag_t     tag;
    logic     err;
    io_data_t data;
  } hart_rslt_t;

endpackage

`default_nettype wire

// File: host_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module host_cmd_decoder
  (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire host_pkg::io_cmd_t   io_cmd_i,
    input  wire logic                io_cmd_v_i,
    input  wire logic                advance_i,
    output host_pkg::hart_req_t      req_o
  );

  logic [host_pkg::REG_W-1:0] reg_field;
  host_pkg::hart_id_t         hart_field;
  logic                       rsvd_hit;
  logic                       reg_ok;
  logic                       dec_err;
  host_pkg::hart_id_t         dec_hart;

  logic                       valid_r;
  host_pkg::io_op_e           op_r;
  host_pkg::host_reg_e        reg_sel_r;
  host_pkg::hart_id_t         hart_r;
  host_pkg::tag_t             tag_r;
  logic                       err_r;
  host_pkg::io_data_t         data_r;

  // Address fields
  assign reg_field  = io_cmd_i.addr[host_pkg::REG_W-1:0];
  assign hart_field = io_cmd_i.addr[host_pkg::HART_LSB +: host_pkg::HART_W];

  assign rsvd_hit = |(io_cmd_i.addr & host_pkg::ADDR_RSVD_MASK);

  always_comb
  begin
    case (reg_field)
      host_pkg::REG_TRACE_EN,
      host_pkg::REG_FINISH:
      begin
        reg_ok = 1'b1;
      end
      default:
      begin
        reg_ok = 1'b0;
      end
    endcase
  end

  assign dec_err = rsvd_hit | ~reg_ok;

  // Errored requests are steered to unit 0
  assign dec_hart = dec_err ? host_pkg::hart_id_t'(0) : hart_field;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      valid_r <= 1'b0;
    end
    else if (advance_i)
    begin
      valid_r <= io_cmd_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (advance_i)
    begin
      op_r      <= io_cmd_i.op;
      reg_sel_r <= host_pkg::host_reg_e'(reg_field);
      hart_r    <= dec_hart;
      tag_r     <= io_cmd_i.tag;
      err_r     <= dec_err;
      data_r    <= io_cmd_i.data;
    end
  end

  always_comb
  begin
    req_o         = '0;
    req_o.valid   = valid_r;
    req_o.op      = op_r;
    req_o.reg_sel = reg_sel_r;
    req_o.hart    = hart_r;
    req_o.tag     = tag_r;
    req_o.err     = err_r;
    req_o.data    = data_r;
  end

endmodule

`default_nettype wire

// File: host_hart_regs.sv
`timescale 1ns/1ns
`default_nettype none

module host_hart_regs
  (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire host_pkg::hart_id_t  hart_id_i,
    input  wire host_pkg::hart_req_t req_i,
    input  wire logic                advance_i,
    output host_pkg::hart_rslt_t     rslt_o,
    output host_pkg::trace_en_t      trace_en_o,
    output logic                     finish_o
  );

  logic                 sel;
  logic                 do_write;
  host_pkg::io_data_t   rd_data;

  host_pkg::trace_en_t  trace_r;
  logic                 finish_r;
  host_pkg::exit_code_t exit_r;

  logic                 rslt_v_r;
  host_pkg::io_op_e     rslt_op_r;
  host_pkg::tag_t       rslt_tag_r;
  logic                 rslt_err_r;
  host_pkg::io_data_t   rslt_data_r;

  // Only unit 0 ever matches an errored request
  assign sel      = req_i.valid && (req_i.hart == hart_id_i);
  assign do_write = sel && !req_i.err && (req_i.op == host_pkg::IO_WRITE);

  always_comb
  begin
    case (req_i.reg_sel)
      host_pkg::REG_TRACE_EN:
      begin
        rd_data = host_pkg::io_data_t'(trace_r);
      end
      host_pkg::REG_FINISH:
      begin
        // Exit code in 7:0, finish flag in bit 8
        rd_data = host_pkg::io_data_t'({finish_r, exit_r});
      end
      default:
      begin
        rd_data = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      trace_r  <= '0;
      finish_r <= 1'b0;
      exit_r   <= '0;
    end
    else if (advance_i && do_write)
    begin
      case (req_i.reg_sel)
        host_pkg::REG_TRACE_EN:
        begin
          trace_r <= req_i.data[host_pkg::TRACE_W-1:0];
        end
        host_pkg::REG_FINISH:
        begin
          finish_r <= 1'b1;
          exit_r   <= req_i.data[host_pkg::EXIT_W-1:0];
        end
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rslt_v_r <= 1'b0;
    end
    else if (advance_i)
    begin
      rslt_v_r <= sel;
    end
  end

  // Writes and errors return zero data
  always_ff @(posedge clk_i)
  begin
    if (advance_i)
    begin
      rslt_op_r   <= req_i.op;
      rslt_tag_r  <= req_i.tag;
      rslt_err_r  <= req_i.err;
      rslt_data_r <= (req_i.err || req_i.op == host_pkg::IO_WRITE) ? '0 : rd_data;
    end
  end

  always_comb
  begin
    rslt_o       = '0;
    rslt_o.valid = rslt_v_r;
    rslt_o.op    = rslt_op_r;
    rslt_o.tag   = rslt_tag_r;
    rslt_o.err   = rslt_err_r;
    rslt_o.data  = rslt_data_r;
  end

  assign trace_en_o = trace_r;
  assign finish_o   = finish_r;

endmodule

`default_nettype wire

// File: host_resp_collector.sv
`timescale 1ns/1ns
`default_nettype none

module host_resp_collector
  (
    input  wire logic                                            clk_i,
    input  wire logic                                            reset_i,
    input  wire host_pkg::hart_rslt_t [host_pkg::NUM_HARTS-1:0]  rslt_i,
    input  wire logic [host_pkg::NUM_HARTS-1:0]                  finish_i,
    input  wire logic                                            io_resp_ready_i,
    output host_pkg::io_resp_t                                   io_resp_o,
    output logic                                                 io_resp_v_o,
    output logic                                                 advance_o,
    output logic                                                 all_done_o
  );

  host_pkg::hart_rslt_t sel_rslt;
  logic                 advance;

  logic                 resp_v_r;
  host_pkg::io_resp_t   resp_r;
  logic                 all_done_r;

  // At most one unit holds a valid result per cycle
  always_comb
  begin
    sel_rslt = '0;
    for (int i = 0; i < host_pkg::NUM_HARTS; i++)
    begin
      if (rslt_i[i].valid)
      begin
        sel_rslt = rslt_i[i];
      end
    end
  end

  // Pipeline moves when the output slot is empty or draining
  assign advance = ~resp_v_r | io_resp_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r <= 1'b0;
    end
    else if (advance)
    begin
      resp_v_r <= sel_rslt.valid;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (advance)
    begin
      resp_r.op   <= sel_rslt.op;
      resp_r.tag  <= sel_rslt.tag;
      resp_r.err  <= sel_rslt.err;
      resp_r.data <= sel_rslt.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      all_done_r <= 1'b0;
    end
    else
    begin
      all_done_r <= &finish_i;
    end
  end

  assign io_resp_o   = resp_r;
  assign io_resp_v_o = resp_v_r;
  assign advance_o   = advance;
  assign all_done_o  = all_done_r;

endmodule

`default_nettype wire

// File: io_host.sv
`timescale 1ns/1ns
`default_nettype none

module io_host
  (
    input  wire logic                                           clk_i,
    input  wire logic                                           reset_i,

    input  wire host_pkg::io_cmd_t                              io_cmd_i,
    input  wire logic                                           io_cmd_v_i,
    output logic                                                io_cmd_ready_o,

    output host_pkg::io_resp_t                                  io_resp_o,
    output logic                                                io_resp_v_o,
    input  wire logic                                           io_resp_ready_i,

    output host_pkg::trace_en_t [host_pkg::NUM_HARTS-1:0]       trace_en_o,
    output logic [host_pkg::NUM_HARTS-1:0]                      finish_o,
    output logic                                                all_done_o
  );

  host_pkg::hart_req_t                             req;
  host_pkg::hart_rslt_t [host_pkg::NUM_HARTS-1:0]  rslt;

  // io_cmd_ready_o doubles as the shared advance
  host_cmd_decoder u_decoder
    (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .io_cmd_i  (io_cmd_i),
      .io_cmd_v_i(io_cmd_v_i),
      .advance_i (io_cmd_ready_o),
      .req_o     (req)
    );

  for (genvar i = 0; i < host_pkg::NUM_HARTS; i++)
  begin : g_hart
    host_hart_regs u_hart
      (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .hart_id_i (host_pkg::hart_id_t'(i)),
        .req_i     (req),
        .advance_i (io_cmd_ready_o),
        .rslt_o    (rslt[i]),
        .trace_en_o(trace_en_o[i]),
        .finish_o  (finish_o[i])
      );
  end

  host_resp_collector u_collector
    (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .rslt_i         (rslt),
      .finish_i       (finish_o),
      .io_resp_ready_i(io_resp_ready_i),
      .io_resp_o      (io_resp_o),
      .io_resp_v_o    (io_resp_v_o),
      .advance_o      (io_cmd_ready_o),
      .all_done_o     (all_done_o)
    );

endmodule

`default_nettype wire

// File: tb_io_host_tests.svh
task automatic reset_state();
  #1;
  check_bit("reset", 1'b0, io_resp_v_o);
  check_bit("reset", 1'b1, io_cmd_ready_o);
  check_hart_outputs("reset");
endtask

// Low bits carry the hart number so every value differs
task automatic trace_enables();
  host_pkg::io_cmd_t  cmd;
  host_pkg::io_data_t rnd;
  host_pkg::hart_id_t hid;
  for (int h = 0; h < host_pkg::NUM_HARTS; h++)
  begin
    hid      = host_pkg::hart_id_t'(h);
    rnd      = take_bits(14);
    cmd.op   = host_pkg::IO_WRITE;
    cmd.addr = make_addr(hid, 4'd0);
    cmd.tag  = host_pkg::tag_t'(h + 3);
    cmd.data = {rnd[61:0], hid};
    do_cmd("trace_write", cmd);
    check_trace("trace_write", cmd.data[host_pkg::TRACE_W-1:0], trace_en_o[hid]);
    cmd.op   = host_pkg::IO_READ;
    cmd.tag  = host_pkg::tag_t'(h + 9);
    cmd.data = '0;
    do_cmd("trace_read", cmd);
  end
  check_hart_outputs("trace_enables");
endtask

task automatic finish_and_done();
  host_pkg::io_cmd_t  cmd;
  host_pkg::hart_id_t hid;
  for (int h = 0; h < host_pkg::NUM_HARTS; h++)
  begin
    hid      = host_pkg::hart_id_t'(h);
    cmd.op   = host_pkg::IO_WRITE;
    cmd.addr = make_addr(hid, 4'd1);
    cmd.tag  = host_pkg::tag_t'(h);
    cmd.data = take_bits(16);
    do_cmd("finish_write", cmd);
    check_bit("finish_write", 1'b1, finish_o[hid]);
    check_bit("all_done", h == host_pkg::NUM_HARTS - 1, all_done_o);
    cmd.op   = host_pkg::IO_READ;
    cmd.data = '0;
    do_cmd("finish_read", cmd);
  end
  check_hart_outputs("finish");
endtask

task automatic unmapped_addresses();
  host_pkg::io_cmd_t cmd;
  cmd.op   = host_pkg::IO_WRITE;
  cmd.tag  = 4'ha;
  cmd.data = 64'h7ff;
  cmd.addr = make_addr(2'd1, 4'd0) | 20'h80000;
  do_cmd("unmapped_high", cmd);
  cmd.addr = make_addr(2'd2, 4'd1) | 20'h00020;
  do_cmd("unmapped_mid", cmd);
  cmd.addr = make_addr(2'd3, 4'd5);
  do_cmd("unmapped_reg", cmd);
  // Exit code of hart 2 must be untouched
  cmd.op   = host_pkg::IO_READ;
  cmd.addr = make_addr(2'd2, 4'd1);
  do_cmd("unmapped_read", cmd);
  check_hart_outputs("unmapped");
endtask

task automatic backpressure_stream();
  host_pkg::io_cmd_t  cmds  [$];
  host_pkg::io_resp_t exp_q [$];
  host_pkg::io_cmd_t  cmd;
  host_pkg::io_data_t rnd;
  int                 rcvd;
  int                 sent;
  for (int n = 0; n < STREAM_LEN; n++)
  begin
    rnd      = take_bits(1);
    cmd.op   = host_pkg::io_op_e'(rnd[0]);
    rnd      = take_bits(3);
    cmd.addr = make_addr(rnd[2:1], {3'b000, rnd[0]});
    rnd      = take_bits(4);
    cmd.tag  = rnd[3:0];
    cmd.data = take_bits(16);
    exp_q.push_back(model_cmd(cmd));
    cmds.push_back(cmd);
  end
  rcvd = 0;
  sent = 0;
  fork
    begin : sender
      foreach (cmds[i])
      begin
        send_cmd(cmds[i]);
        sent++;
      end
      @(negedge clk_i);
      io_cmd_v_i = 1'b0;
    end
    begin : receiver
      while (rcvd < STREAM_LEN)
      begin
        @(negedge clk_i);
        rnd = take_bits(1);
        io_resp_ready_i = rnd[0];
        #1;
        if (io_resp_v_o && io_resp_ready_i)
        begin
          if (rcvd >= sent)
          begin
            $display("A response arrived with no command outstanding");
            fail_run();
          end
          else
          begin
            check_resp("backpressure", exp_q.pop_front(), io_resp_o);
            rcvd++;
          end
        end
      end
    end
  join
  @(negedge clk_i);
  io_resp_ready_i = 1'b1;
  repeat (4)
  begin
    @(negedge clk_i);
    check_bit("backpressure_extra", 1'b0, io_resp_v_o);
  end
  check_hart_outputs("backpressure");
endtask

// File: tb_io_host.sv
`timescale 1ns/1ns
`default_nettype none

module tb_io_host;

  localparam int HALF_NS      = 2;
  localparam int RESET_CYCLES = 4;
  localparam int STREAM_LEN   = 40;
  // Directed commands plus the random stream
  localparam int NUM_CMDS     = 20 + STREAM_LEN;
  localparam int WATCHDOG_NS  = (NUM_CMDS * 200 + RESET_CYCLES) * 2 * HALF_NS;

  logic                                          clk_i;
  logic                                          reset_i;
  host_pkg::io_cmd_t                             io_cmd_i;
  logic                                          io_cmd_v_i;
  logic                                          io_cmd_ready_o;
  host_pkg::io_resp_t                            io_resp_o;
  logic                                          io_resp_v_o;
  logic                                          io_resp_ready_i;
  host_pkg::trace_en_t [host_pkg::NUM_HARTS-1:0] trace_en_o;
  logic [host_pkg::NUM_HARTS-1:0]                finish_o;
  logic                                          all_done_o;

  logic [31:0]          lfsr_state;
  host_pkg::trace_en_t  model_trace  [host_pkg::NUM_HARTS];
  logic                 model_finish [host_pkg::NUM_HARTS];
  host_pkg::exit_code_t model_exit   [host_pkg::NUM_HARTS];

  io_host dut_i (.*);

  always #HALF_NS clk_i = ~clk_i;

  task automatic fail_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_resp(input string name, input host_pkg::io_resp_t exp,
                            input host_pkg::io_resp_t act);
    if (exp !== act)
    begin
      $write("ERROR %s: expected op=%0d tag=%h err=%b data=%h", name,
             exp.op, exp.tag, exp.err, exp.data);
      $display(", actual op=%0d tag=%h err=%b data=%h",
               act.op, act.tag, act.err, act.data);
      fail_run();
    end
  endtask

  task automatic check_trace(input string name, input host_pkg::trace_en_t exp,
                             input host_pkg::trace_en_t act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected trace_en=%h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      fail_run();
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic host_pkg::io_data_t take_bits(input int n);
    host_pkg::io_data_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic host_pkg::io_addr_t make_addr(input host_pkg::hart_id_t hart,
                                                   input logic [3:0] reg_num);
    return {6'd0, hart, 8'd0, reg_num};
  endfunction

  // Builds the expected response and updates the model on writes
  function automatic host_pkg::io_resp_t model_cmd(input host_pkg::io_cmd_t cmd);
    host_pkg::io_resp_t resp;
    host_pkg::hart_id_t hart;
    logic [3:0]         reg_num;
    logic               unmapped;
    hart     = cmd.addr[13:12];
    reg_num  = cmd.addr[3:0];
    unmapped = (cmd.addr[19:14] != 6'd0) || (cmd.addr[11:4] != 8'd0) || (reg_num > 4'd1);
    resp.op   = cmd.op;
    resp.tag  = cmd.tag;
    resp.err  = unmapped;
    resp.data = '0;
    if (!unmapped && cmd.op == host_pkg::IO_WRITE)
    begin
      if (reg_num == 4'd0)
      begin
        model_trace[hart] = cmd.data[host_pkg::TRACE_W-1:0];
      end
      else
      begin
        model_finish[hart] = 1'b1;
        model_exit[hart]   = cmd.data[host_pkg::EXIT_W-1:0];
      end
    end
    else if (!unmapped)
    begin
      if (reg_num == 4'd0)
      begin
        resp.data = {53'd0, model_trace[hart]};
      end
      else
      begin
        resp.data = {55'd0, model_finish[hart], model_exit[hart]};
      end
    end
    return resp;
  endfunction

  // Returns on the edge where the command transfers
  task automatic send_cmd(input host_pkg::io_cmd_t cmd);
    logic taken;
    @(negedge clk_i);
    io_cmd_i   = cmd;
    io_cmd_v_i = 1'b1;
    taken      = 1'b0;
    while (!taken)
    begin
      #1;
      taken = io_cmd_ready_o;
      @(posedge clk_i);
      if (!taken)
      begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic do_cmd(input string name, input host_pkg::io_cmd_t cmd);
    host_pkg::io_resp_t exp;
    host_pkg::io_resp_t got;
    logic               taken;
    exp = model_cmd(cmd);
    send_cmd(cmd);
    @(negedge clk_i);
    io_cmd_v_i = 1'b0;
    taken      = 1'b0;
    while (!taken)
    begin
      #1;
      taken = io_resp_v_o && io_resp_ready_i;
      got   = io_resp_o;
      @(negedge clk_i);
    end
    check_resp(name, exp, got);
  endtask

  task automatic check_hart_outputs(input string name);
    host_pkg::hart_id_t hid;
    logic               all_fin;
    all_fin = 1'b1;
    for (int h = 0; h < host_pkg::NUM_HARTS; h++)
    begin
      hid = host_pkg::hart_id_t'(h);
      check_trace(name, model_trace[hid], trace_en_o[hid]);
      check_bit(name, model_finish[hid], finish_o[hid]);
      all_fin = all_fin & model_finish[hid];
    end
    check_bit(name, all_fin, all_done_o);
  endtask

`include "tb_io_host_tests.svh"

  initial
  begin
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    io_cmd_i        = '0;
    io_cmd_v_i      = 1'b0;
    io_resp_ready_i = 1'b1;
    lfsr_state      = 32'h723eadca;
    model_trace     = '{default: '0};
    model_finish    = '{default: 1'b0};
    model_exit      = '{default: '0};
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    reset_state();
    trace_enables();
    finish_and_done();
    unmapped_addresses();
    backpressure_stream();
    $display("PASS: all tests");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete within the allowed time");
    fail_run();
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
host_pkg.sv
host_cmd_decoder.sv
host_hart_regs.sv
host_resp_collector.sv
io_host.sv
tb_io_host.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ns --top-module tb_io_host -f list.f \
  -o tb_io_host_sim || exit 1
./obj_dir/tb_io_host_sim | tee /dev/stderr | grep -F "PASS: all tests" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
